/* src/tl_bridge_cfg.svh */
// Build configuration for the component to TL-UL bridge
// Bus field widths, response latency, register map size
// and the identification word of the register target

`ifndef TL_BRIDGE_CFG_SVH
`define TL_BRIDGE_CFG_SVH

// ------------------------------------------------------------
// TL-UL field widths
// ------------------------------------------------------------
`define TL_AW   32    // Address bits
`define TL_DW   32    // Data bits
`define TL_BC   4     // Bytes per word, one mask bit each
`define TL_IW   2     // Source ID bits
`define TL_SZW  2     // Size field bits, log2 of bytes
`define TL_UW   16    // a_user sideband bits

// ------------------------------------------------------------
// Target behaviour
// ------------------------------------------------------------
`define RSP_LAT     2              // Cycles from A accept to d_valid, min 1
`define REG_NUM     16             // Word registers in the target
`define REG_ID_VAL  32'h7c1a_0001  // Read-only contents of register 0

`endif

/* src/tl_bridge_pkg.sv */
// Shared TL-UL types for the bridge
// A and D channel opcode encodings
// Integrity field widths and the a_user layout

`default_nettype none
`include "tl_bridge_cfg.svh"

package tl_bridge_pkg;

    // A channel opcodes
    typedef enum logic [2:0] {
        PutFullData    = 3'h0,  // Write with every byte lane set
        PutPartialData = 3'h1,  // Write with a sparse mask
        Get            = 3'h4   // Read
    } tl_a_op_e;

    // D channel opcodes
    typedef enum logic [2:0] {
        AccessAck     = 3'h0,   // Write response, no data
        AccessAckData = 3'h1    // Read response with data
    } tl_d_op_e;

    // ------------------------------------------------------------
    // a_user layout, top bit down
    //   [15:10]  zero, the instruction type is always a data access
    //   [9:4]    command integrity
    //   [3:0]    data integrity, one bit per byte lane
    // Command bits 0..3 are the even parity of address bytes 0..3,
    // bit 4 the parity of the opcode, bit 5 the parity of the mask
    // ------------------------------------------------------------
    localparam int unsigned CMD_INTG_W  = 6;
    localparam int unsigned DATA_INTG_W = 4;

    // Zero padding above the integrity bits
    localparam int unsigned USER_PAD_W = `TL_UW - CMD_INTG_W - DATA_INTG_W;

endpackage

`default_nettype wire

/* src/tl_bus_if.sv */
// TL-UL bus between one host and one device
// A channel request and D channel response signals
// Host and device modports

`timescale 1ns/1ps
`default_nettype none
`include "tl_bridge_cfg.svh"

interface tl_bus_if;
    import tl_bridge_pkg::*;

    // A channel, host to device
    logic                 a_valid;
    logic                 a_ready;    // From device
    tl_a_op_e             a_opcode;
    logic [2:0]           a_param;    // Always zero here
    logic [`TL_SZW-1:0]   a_size;
    logic [`TL_IW-1:0]    a_source;
    logic [`TL_AW-1:0]    a_address;  // Byte address
    logic [`TL_BC-1:0]    a_mask;
    logic [`TL_DW-1:0]    a_data;
    logic [`TL_UW-1:0]    a_user;     // Integrity sideband

    // D channel, device to host
    logic                 d_valid;
    logic                 d_ready;    // From host
    tl_d_op_e             d_opcode;
    logic [`TL_SZW-1:0]   d_size;
    logic [`TL_IW-1:0]    d_source;   // Echo of a_source
    logic [`TL_DW-1:0]    d_data;
    logic                 d_error;

    // Requester side
    modport host (
        output a_valid, a_opcode, a_param, a_size, a_source,
        output a_address, a_mask, a_data, a_user, d_ready,
        input  a_ready, d_valid, d_opcode, d_size, d_source,
        input  d_data, d_error
    );

    // Responder side
    modport device (
        input  a_valid, a_opcode, a_param, a_size, a_source,
        input  a_address, a_mask, a_data, a_user, d_ready,
        output a_ready, d_valid, d_opcode, d_size, d_source,
        output d_data, d_error
    );

endinterface

`default_nettype wire

/* src/tl_intg_gen.sv */
// Integrity generator for TL-UL A channel requests
// Even parity per address byte, opcode and mask
// Even parity per data byte lane
// Purely combinational, used on both ends of the bus

`timescale 1ns/1ps
`default_nettype none
`include "tl_bridge_cfg.svh"

module tl_intg_gen (
    input  logic [`TL_AW-1:0]                     addr_i,
    input  tl_bridge_pkg::tl_a_op_e               opcode_i,
    input  logic [`TL_BC-1:0]                     mask_i,
    input  logic [`TL_DW-1:0]                     data_i,
    output logic [tl_bridge_pkg::CMD_INTG_W-1:0]  cmd_intg_o,
    output logic [tl_bridge_pkg::DATA_INTG_W-1:0] data_intg_o
);
    import tl_bridge_pkg::*;

    // Command field holds one bit per address byte plus opcode and mask
    localparam int unsigned ADDR_BYTES = CMD_INTG_W - 2;
    localparam int unsigned OP_BIT     = ADDR_BYTES;      // Opcode parity position
    localparam int unsigned MASK_BIT   = ADDR_BYTES + 1;  // Mask parity position

    // ------------------------------------------------------------
    // Command integrity
    // ------------------------------------------------------------
    always_comb begin
        cmd_intg_o = '0;
        // Address bytes, lowest byte in bit 0
        for (int i = 0; i < ADDR_BYTES; i++) begin
            cmd_intg_o[i] = ^addr_i[8*i +: 8];
        end
        cmd_intg_o[OP_BIT]   = ^opcode_i;   // Read vs full vs partial write
        cmd_intg_o[MASK_BIT] = ^mask_i;     // Byte enables
    end

    // ------------------------------------------------------------
    // Data integrity
    // ------------------------------------------------------------
    // Data is zero on a read, so the bits come out zero as well
    always_comb begin
        data_intg_o = '0;
        for (int b = 0; b < DATA_INTG_W; b++) begin
            data_intg_o[b] = ^data_i[8*b +: 8];  // Lane b parity
        end
    end

endmodule

`default_nettype wire

/* src/comp2tlul_shim.sv */
// Component port to TL-UL host shim
// One request per access, held until the response returns
// Opcode and mask selection, integrity sideband
// Response matching, read data gating and error split

`timescale 1ns/1ps
`default_nettype none
`include "tl_bridge_cfg.svh"

module comp2tlul_shim (
    input  logic              clk,
    input  logic              rst_n,

    // Component side
    input  logic              dv_i,      // Access valid, held while hld_o
    input  logic              write_i,
    input  logic [`TL_AW-1:0] addr_i,    // Byte address
    input  logic [`TL_IW-1:0] id_i,
    input  logic [`TL_DW-1:0] wdata_i,
    input  logic [`TL_BC-1:0] wstrb_i,
    input  logic [2:0]        size_i,
    output logic [`TL_DW-1:0] rdata_o,
    output logic              hld_o,
    output logic              rd_err_o,
    output logic              wr_err_o,

    // Bus side
    tl_bus_if.host            tl
);
    import tl_bridge_pkg::*;

    // Which response the outstanding request is waiting for
    typedef enum logic [1:0] {
        TXN_NONE = 2'b00,
        TXN_GET  = 2'b01,
        TXN_PUT  = 2'b10
    } txn_state_e;

    txn_state_e              txn_q;
    logic                    pending_q;   // Request sent, response not yet seen
    tl_a_op_e                opcode;
    logic [`TL_BC-1:0]       mask;
    logic [`TL_DW-1:0]       wdata;
    logic [CMD_INTG_W-1:0]   cmd_intg;
    logic [DATA_INTG_W-1:0]  data_intg;
    logic                    a_fire;
    logic                    rsp_match;
    logic                    rsp_done;

    // ------------------------------------------------------------
    // Request
    // ------------------------------------------------------------
    assign opcode = !write_i ? Get : ((&wstrb_i) ? PutFullData : PutPartialData);
    assign mask   = !write_i ? '1 : wstrb_i;     // Full word on reads
    assign wdata  = !write_i ? '0 : wdata_i;     // No data on reads

    assign tl.a_valid   = dv_i & ~pending_q;     // Never a second request in flight
    assign tl.a_opcode  = opcode;
    assign tl.a_param   = 3'h0;
    assign tl.a_size    = size_i[`TL_SZW-1:0];
    assign tl.a_source  = id_i;
    assign tl.a_address = addr_i;
    assign tl.a_mask    = mask;
    assign tl.a_data    = wdata;
    assign tl.a_user    = {{USER_PAD_W{1'b0}}, cmd_intg, data_intg};

    tl_intg_gen u_intg_gen (
        .addr_i      (addr_i),
        .opcode_i    (opcode),
        .mask_i      (mask),
        .data_i      (wdata),
        .cmd_intg_o  (cmd_intg),
        .data_intg_o (data_intg)
    );

    assign a_fire = tl.a_valid & tl.a_ready;

    // ------------------------------------------------------------
    // Transaction tracking
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txn_q <= TXN_NONE;
        end else if (a_fire) begin
            txn_q <= (opcode == Get) ? TXN_GET : TXN_PUT;
        end else if (rsp_done) begin
            txn_q <= TXN_NONE;                   // Response consumed
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
        end else if (a_fire) begin
            pending_q <= 1'b1;
        end else if (rsp_done) begin
            pending_q <= 1'b0;
        end
    end

    // Response opcode must fit the request kind
    assign rsp_match = ((txn_q == TXN_GET) && (tl.d_opcode == AccessAckData)) ||
                       ((txn_q == TXN_PUT) && (tl.d_opcode == AccessAck));
    assign rsp_done  = tl.d_valid & rsp_match;

    // ------------------------------------------------------------
    // Response
    // ------------------------------------------------------------
    assign tl.d_ready = tl.d_valid;              // Always accept

    assign hld_o    = dv_i & ~rsp_done;          // Released in the response cycle
    assign rdata_o  = (rsp_done && (tl.d_source == id_i)) ? tl.d_data : '0;
    assign rd_err_o = rsp_done & ~write_i & tl.d_error;
    assign wr_err_o = rsp_done &  write_i & tl.d_error;

endmodule

`default_nettype wire

/* src/tl_reg_target.sv */
// TL-UL register file device
// 16 word registers, register 0 is a read-only ID
// Integrity check on every request, fixed response latency
// Error response on bad integrity, bad index or ID write

`timescale 1ns/1ps
`default_nettype none
`include "tl_bridge_cfg.svh"

module tl_reg_target (
    input  logic      clk,
    input  logic      rst_n,
    tl_bus_if.device  tl
);
    import tl_bridge_pkg::*;

    localparam int unsigned OFF_W = $clog2(`TL_BC);     // Byte offset bits
    localparam int unsigned IDX_W = $clog2(`REG_NUM);   // Register index bits
    localparam int unsigned CNT_W = $clog2(`RSP_LAT + 1);

    logic [`TL_DW-1:0]         regs_q [1:`REG_NUM-1];   // Register 0 is not stored
    logic                      busy_q;                  // Response outstanding
    logic [CNT_W-1:0]          cnt_q;                   // Cycles left to d_valid

    // Response payload
    tl_d_op_e                  d_opcode_q;
    logic [`TL_IW-1:0]         d_source_q;
    logic [`TL_SZW-1:0]        d_size_q;
    logic [`TL_DW-1:0]         d_data_q;
    logic                      d_error_q;

    logic                      a_fire;
    logic                      d_fire;
    logic [CMD_INTG_W-1:0]     cmd_intg_exp;
    logic [DATA_INTG_W-1:0]    data_intg_exp;
    logic                      intg_err;
    logic                      is_put;
    logic [`TL_AW-OFF_W-1:0]   word_addr;
    logic [IDX_W-1:0]          idx;
    logic                      oob;
    logic                      id_wr;
    logic                      req_err;
    logic [`TL_DW-1:0]         rd_val;

    // ------------------------------------------------------------
    // Request decode
    // ------------------------------------------------------------
    tl_intg_gen u_intg_chk (
        .addr_i      (tl.a_address),
        .opcode_i    (tl.a_opcode),
        .mask_i      (tl.a_mask),
        .data_i      (tl.a_data),
        .cmd_intg_o  (cmd_intg_exp),
        .data_intg_o (data_intg_exp)
    );

    // Pad bits count as part of the check
    assign intg_err  = tl.a_user != {{USER_PAD_W{1'b0}}, cmd_intg_exp, data_intg_exp};

    assign is_put    = (tl.a_opcode != Get);
    assign word_addr = tl.a_address[`TL_AW-1:OFF_W];
    assign idx       = word_addr[IDX_W-1:0];
    assign oob       = (word_addr >= `REG_NUM);        // Past the register file
    assign id_wr     = is_put & ~oob & (idx == '0);    // ID register is read-only
    assign req_err   = intg_err | oob | id_wr;

    // Read mux
    always_comb begin
        if (idx == '0) begin
            rd_val = `REG_ID_VAL;
        end else begin
            rd_val = regs_q[idx];
        end
    end

    assign a_fire = tl.a_valid & tl.a_ready;
    assign d_fire = tl.d_valid & tl.d_ready;

    // ------------------------------------------------------------
    // Register file
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `REG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (a_fire && is_put && !req_err) begin
            for (int b = 0; b < `TL_BC; b++) begin
                if (tl.a_mask[b]) regs_q[idx][8*b +: 8] <= tl.a_data[8*b +: 8];
            end
        end
    end

    // ------------------------------------------------------------
    // Response timing
    // ------------------------------------------------------------
    // Counter starts one below the latency since the accept cycle counts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (a_fire) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(`RSP_LAT - 1);
        end else if (d_fire) begin
            busy_q <= 1'b0;                            // Free for the next request
        end else if (busy_q && (cnt_q != '0)) begin
            cnt_q  <= cnt_q - 1'b1;
        end
    end

    // Payload captured at accept
    always_ff @(posedge clk) begin
        if (a_fire) begin
            d_opcode_q <= is_put ? AccessAck : AccessAckData;
            d_source_q <= tl.a_source;
            d_size_q   <= tl.a_size;
            d_data_q   <= (is_put || req_err) ? '0 : rd_val;  // Out of range reads give zero
            d_error_q  <= req_err;
        end
    end

    assign tl.a_ready  = ~busy_q;                      // One outstanding at most
    assign tl.d_valid  = busy_q & (cnt_q == '0);
    assign tl.d_opcode = d_opcode_q;
    assign tl.d_source = d_source_q;
    assign tl.d_size   = d_size_q;
    assign tl.d_data   = d_data_q;
    assign tl.d_error  = d_error_q;

endmodule

`default_nettype wire

/* src/comp_tl_top.sv */
// Top level of the component to TL-UL bridge
// Shim on the host side, register target on the device side
// Joined by one TL-UL bus interface

`timescale 1ns/1ps
`default_nettype none
`include "tl_bridge_cfg.svh"

module comp_tl_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              dv_i,
    input  logic              write_i,
    input  logic [`TL_AW-1:0] addr_i,
    input  logic [`TL_IW-1:0] id_i,
    input  logic [`TL_DW-1:0] wdata_i,
    input  logic [`TL_BC-1:0] wstrb_i,
    input  logic [2:0]        size_i,
    output logic [`TL_DW-1:0] rdata_o,
    output logic              hld_o,
    output logic              rd_err_o,
    output logic              wr_err_o
);

    tl_bus_if tl_bus ();                  // Shim to target

    comp2tlul_shim u_shim (
        .clk      (clk),
        .rst_n    (rst_n),
        .dv_i     (dv_i),
        .write_i  (write_i),
        .addr_i   (addr_i),
        .id_i     (id_i),
        .wdata_i  (wdata_i),
        .wstrb_i  (wstrb_i),
        .size_i   (size_i),
        .rdata_o  (rdata_o),
        .hld_o    (hld_o),
        .rd_err_o (rd_err_o),
        .wr_err_o (wr_err_o),
        .tl       (tl_bus.host)
    );

    tl_reg_target u_target (
        .clk   (clk),
        .rst_n (rst_n),
        .tl    (tl_bus.device)
    );

endmodule

`default_nettype wire

/* tests/comp_tl_tb.sv */
// Testbench for the component to TL-UL bridge
// Stimulus table with full, partial, ID and out-of-range accesses
// Shadow register model, latency and back-to-back checks
// Clock, reset and watchdog

`timescale 1ns/1ps
`default_nettype none
`include "tl_bridge_cfg.svh"

module comp_tl_tb;

    localparam int N_ENT  = 54;                          // Table length
    localparam int LAT    = `RSP_LAT;
    localparam int WD_CYC = 3 + N_ENT * (LAT + 4) + 50;  // Watchdog budget in cycles

    typedef struct packed {
        logic              wr;
        logic [`TL_AW-1:0] addr;
        logic [`TL_IW-1:0] id;
        logic [`TL_DW-1:0] data;
        logic [`TL_BC-1:0] strb;
        logic              exp_err;
        logic              b2b;      // dv_i stays high from the previous entry
    } ent_t;

    logic              clk;
    logic              rst_n;
    logic              dv_i;
    logic              write_i;
    logic [`TL_AW-1:0] addr_i;
    logic [`TL_IW-1:0] id_i;
    logic [`TL_DW-1:0] wdata_i;
    logic [`TL_BC-1:0] wstrb_i;
    logic [2:0]        size_i;
    logic [`TL_DW-1:0] rdata_o;
    logic              hld_o;
    logic              rd_err_o;
    logic              wr_err_o;

    ent_t              tab [N_ENT];
    int                n_ent;
    logic [`TL_DW-1:0] shadow [`REG_NUM];   // Expected register contents
    logic [31:0]       rng;
    int                err_cnt;
    int                chk_cnt;

    comp_tl_top dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .dv_i     (dv_i),
        .write_i  (write_i),
        .addr_i   (addr_i),
        .id_i     (id_i),
        .wdata_i  (wdata_i),
        .wstrb_i  (wstrb_i),
        .size_i   (size_i),
        .rdata_o  (rdata_o),
        .hld_o    (hld_o),
        .rd_err_o (rd_err_o),
        .wr_err_o (wr_err_o)
    );

    always #5 clk = ~clk;                   // 10 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------
    task automatic add_entry(input logic wr, input logic [31:0] addr, input logic [1:0] id,
                             input logic [31:0] data, input logic [3:0] strb);
        ent_t        e;
        logic [31:0] widx;
        widx      = addr >> 2;
        e.wr      = wr;
        e.addr    = addr;
        e.id      = id;
        e.data    = data;
        e.strb    = strb;
        // Out of range, or a write to the read-only ID word
        e.exp_err = (widx >= `REG_NUM) || (wr && (widx == 0));
        e.b2b     = (n_ent % 3 == 2);        // Every third entry follows without a gap
        if (n_ent < N_ENT) tab[n_ent] = e;
        n_ent++;
    endtask

    task automatic build_table();
        int         r;
        logic [3:0] s;
        n_ent = 0;
        // Full writes to 1..15, then read all back
        for (r = 1; r < `REG_NUM; r++) begin
            rng = xorshift32(rng);
            add_entry(1'b1, r * 4, r[1:0], rng, 4'hf);
        end
        for (r = 1; r < `REG_NUM; r++) add_entry(1'b0, r * 4, r[1:0] + 2'd1, '0, 4'h0);
        // Partial writes, each one read back
        for (int k = 0; k < 8; k++) begin
            rng = xorshift32(rng);
            r   = 1 + int'(rng[7:4]) % 15;
            s   = rng[3:0];
            if (s == 4'h0 || s == 4'hf) s = 4'ha;   // Keep the strobes mixed
            rng = xorshift32(rng);
            add_entry(1'b1, r * 4, k[1:0], rng, s);
            add_entry(1'b0, r * 4, k[1:0], '0, 4'h0);
        end
        // ID register
        add_entry(1'b0, 32'h0, 2'd0, '0, 4'h0);
        rng = xorshift32(rng);
        add_entry(1'b1, 32'h0, 2'd1, rng, 4'hf);
        add_entry(1'b0, 32'h0, 2'd2, '0, 4'h0);
        // Past the register file
        add_entry(1'b0, 32'h40, 2'd3, '0, 4'h0);
        add_entry(1'b1, 32'h40, 2'd0, rng, 4'hf);
        add_entry(1'b0, 32'h3c0, 2'd1, '0, 4'h0);
        add_entry(1'b1, 32'hffff_fffc, 2'd2, ~rng, 4'h3);
        add_entry(1'b0, 32'h8000_0004, 2'd3, '0, 4'h0);
    endtask

    // ------------------------------------------------------------
    // One access with checks
    // ------------------------------------------------------------
    task automatic apply_entry(input int i);
        ent_t        e;
        logic [31:0] widx;
        logic [31:0] exp_data;
        int          exp_lat;
        int          cyc;
        e        = tab[i];
        widx     = e.addr >> 2;
        exp_lat  = e.b2b ? LAT + 1 : LAT;   // Waits one cycle for the previous response
        exp_data = '0;                      // Writes and errors return zero
        if (!e.wr && !e.exp_err) exp_data = shadow[widx];
        // Called on a falling edge
        dv_i    = 1'b1;
        write_i = e.wr;
        addr_i  = e.addr;
        id_i    = e.id;
        wdata_i = e.data;
        wstrb_i = e.strb;
        size_i  = 3'd2;                     // Full word
        cyc     = 0;
        do begin
            @(negedge clk);
            cyc++;
        end while (hld_o && cyc < LAT + 8);
        chk_cnt += 5;
        assert (!hld_o) else begin
            $display("Entry %0d: hld_o never dropped, no response came back", i);
            err_cnt++;
        end
        assert (cyc == exp_lat) else begin
            $display("Fail hld_o entry %0d: low after 0x%0h cycles, expected 0x%0h",
                     i, cyc, exp_lat);
            err_cnt++;
        end
        assert (rdata_o == exp_data) else begin
            $display("Fail rdata_o entry %0d: got 0x%08h expected 0x%08h", i, rdata_o, exp_data);
            err_cnt++;
        end
        assert (rd_err_o == (!e.wr && e.exp_err)) else begin
            $display("Fail rd_err_o entry %0d: got 0x%0h expected 0x%0h",
                     i, rd_err_o, !e.wr && e.exp_err);
            err_cnt++;
        end
        assert (wr_err_o == (e.wr && e.exp_err)) else begin
            $display("Fail wr_err_o entry %0d: got 0x%0h expected 0x%0h",
                     i, wr_err_o, e.wr && e.exp_err);
            err_cnt++;
        end
        // Byte-masked update of the model
        if (e.wr && !e.exp_err) begin
            for (int b = 0; b < `TL_BC; b++) begin
                if (e.strb[b]) shadow[widx][8*b +: 8] = e.data[8*b +: 8];
            end
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        dv_i    = 1'b0;
        write_i = 1'b0;
        addr_i  = '0;
        id_i    = '0;
        wdata_i = '0;
        wstrb_i = '0;
        size_i  = '0;
        err_cnt = 0;
        chk_cnt = 0;
        rng     = 32'hbfcb_8d99;
        shadow[0] = `REG_ID_VAL;
        for (int r = 1; r < `REG_NUM; r++) shadow[r] = '0;   // Reset value
        build_table();
        assert (n_ent == N_ENT) else begin
            $display("Stimulus table holds %0d entries instead of %0d", n_ent, N_ENT);
            err_cnt++;
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < N_ENT; i++) begin
            apply_entry(i);
            if (!(i + 1 < N_ENT && tab[i + 1].b2b)) begin
                dv_i = 1'b0;                // One idle cycle before the next access
                @(negedge clk);
            end
        end
        $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WD_CYC) @(posedge clk);
        $display("Timeout after %0d cycles, the run hung", WD_CYC);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+src
src/tl_bridge_pkg.sv
src/tl_bus_if.sv
src/tl_intg_gen.sv
src/comp2tlul_shim.sv
src/tl_reg_target.sv
src/comp_tl_top.sv
tests/comp_tl_tb.sv

/* Bender.yml */
package:
  name: comp_tl_bridge

export_include_dirs:
  - src

sources:
  # Design, in compile order
  - files:
      - src/tl_bridge_pkg.sv
      - src/tl_bus_if.sv
      - src/tl_intg_gen.sv
      - src/comp2tlul_shim.sv
      - src/tl_reg_target.sv
      - src/comp_tl_top.sv

  # Simulation only
  - target: test
    files:
      - tests/comp_tl_tb.sv
